/* Makefile */
# Verilator flow for the fetch front end

TOP := tb_fe_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* fe_btb.sv */
// direct-mapped branch target buffer
// registered read index and tag compared against the stored tag
`default_nettype none

module fe_btb
  #(parameter int btb_idx_width_p = 6)
   (input  wire               clk_i,
    input  wire               reset_i,
    input  fe_pkg::fe_vaddr_t r_addr_i,
    output fe_pkg::fe_vaddr_t br_tgt_o,
    output logic              br_tgt_v_o,
    input  wire               w_v_i,
    input  fe_pkg::fe_vaddr_t w_addr_i,
    input  fe_pkg::fe_vaddr_t w_tgt_i);

   import fe_pkg::*;

   localparam int els_lp       = 2 ** btb_idx_width_p;
   localparam int tag_lsb_lp   = btb_idx_width_p + 2;
   localparam int tag_width_lp = vaddr_width_c - tag_lsb_lp;

   logic [els_lp-1:0]       valid_r;
   logic [tag_width_lp-1:0] tag_mem [els_lp];
   fe_vaddr_t               tgt_mem [els_lp];

   logic [btb_idx_width_p-1:0] r_idx_r;
   logic [tag_width_lp-1:0]    r_tag_r;
   logic [btb_idx_width_p-1:0] w_idx;

   assign w_idx = w_addr_i[2 +: btb_idx_width_p];

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         valid_r <= '0;
      end
      else if (w_v_i)
      begin
         valid_r[w_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         tag_mem[w_idx] <= w_addr_i[vaddr_width_c-1:tag_lsb_lp];
         tgt_mem[w_idx] <= w_tgt_i;
      end
      r_idx_r <= r_addr_i[2 +: btb_idx_width_p];
      r_tag_r <= r_addr_i[vaddr_width_c-1:tag_lsb_lp];
   end

   // hit one cycle after the read address
   assign br_tgt_v_o = valid_r[r_idx_r] & (tag_mem[r_idx_r] == r_tag_r);
   assign br_tgt_o   = tgt_mem[r_idx_r];

endmodule

`default_nettype wire

/* fe_instr_scan.sv */
// instruction scanner for static prediction
// finds conditional branches and jal, extracts the offset
`default_nettype none

module fe_instr_scan
   (input  fe_pkg::fe_instr_t instr_i,
    output fe_pkg::fe_scan_s  scan_o);

   import fe_pkg::*;

   localparam logic [6:0] op_branch_lp = 7'b1100011;
   localparam logic [6:0] op_jal_lp    = 7'b1101111;

   logic [12:0] b_imm;
   logic [20:0] j_imm;

   // B and J formats scramble the offset bits
   assign b_imm = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
   assign j_imm = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

   always_comb
   begin
      case (instr_i[6:0])
         op_branch_lp:
         begin
            scan_o.scan_class = e_scan_branch;
            scan_o.imm        = {{(vaddr_width_c-13){b_imm[12]}}, b_imm};
         end
         op_jal_lp:
         begin
            scan_o.scan_class = e_scan_jal;
            scan_o.imm        = {{(vaddr_width_c-21){j_imm[20]}}, j_imm};
         end
         default:
         begin
            scan_o.scan_class = e_scan_other;
            scan_o.imm        = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* fe_pc_gen.sv */
// PC generator with next-PC selection, prediction and miss refetch
// packs fetch and exception entries for the fetch queue
`default_nettype none

module fe_pc_gen
  #(parameter int                btb_idx_width_p = 6,
    parameter fe_pkg::fe_vaddr_t first_pc_p      = 39'h80000000)
   (input  wire                     clk_i,
    input  wire                     reset_i,
    input  fe_pkg::fe_cmd_s         fe_cmd_i,
    input  wire                     fe_cmd_v_i,
    output logic                    fe_cmd_ready_o,
    output fe_pkg::fe_icache_req_s  icache_req_o,
    output logic                    icache_req_v_o,
    input  wire                     icache_req_ready_i,
    input  fe_pkg::fe_icache_resp_s icache_resp_i,
    input  wire                     icache_resp_v_i,
    input  wire                     icache_miss_i,
    output logic                    icache_resp_ready_o,
    output fe_pkg::fe_queue_s       fe_queue_o,
    output logic                    fe_queue_v_o,
    input  wire                     fe_queue_ready_i,
    output fe_pkg::fe_vaddr_t       btb_r_addr_o,
    input  fe_pkg::fe_vaddr_t       btb_tgt_i,
    input  wire                     btb_tgt_v_i,
    output logic                    btb_w_v_o,
    output fe_pkg::fe_vaddr_t       btb_w_addr_o,
    output fe_pkg::fe_vaddr_t       btb_w_tgt_o,
    output fe_pkg::fe_instr_t       scan_instr_o,
    input  fe_pkg::fe_scan_s        scan_i);

   import fe_pkg::*;

   // f1 holds the outstanding request, f2 the address to refetch
   fe_vaddr_t pc_f1, pc_f2, npc_r, pc_n, btb_tgt_r, btb_tgt, succ;
   logic      v_f1, sq_f1, run_r, miss_r, npc_v, issue_q, btb_pred_r;
   logic      pcn_v, btb_pred, predict_taken, stall, cmd_fire, issue;
   logic      misaligned, f1_done, live, resp_ok, miss_set;

   assign cmd_fire   = fe_cmd_v_i & fe_cmd_ready_o;
   assign misaligned = fe_cmd_i.pc[1:0] != 2'b00;
   assign live       = v_f1 & ~sq_f1 & ~cmd_fire;

   assign icache_resp_ready_o = fe_queue_ready_i | sq_f1;
   assign stall = ~fe_queue_ready_i | ~icache_req_ready_i
                | (icache_resp_v_i & ~icache_resp_ready_o);
   assign fe_cmd_ready_o = run_r & ~stall;

   assign f1_done  = v_f1 & ((icache_resp_v_i & icache_resp_ready_o) | icache_miss_i);
   assign resp_ok  = live & icache_resp_v_i;
   assign miss_set = live & icache_miss_i;

   // btb hit belongs to pc_f1 in the cycle after issue
   // later cycles use the captured copy
   assign btb_pred = issue_q ? btb_tgt_v_i : btb_pred_r;
   assign btb_tgt  = issue_q ? btb_tgt_i : btb_tgt_r;

   assign scan_instr_o  = icache_resp_i.instr;
   assign predict_taken = ((scan_i.scan_class == e_scan_branch) & scan_i.imm[vaddr_width_c-1])
                        | (scan_i.scan_class == e_scan_jal);

   always_comb
   begin
      if (btb_pred)
         succ = btb_tgt;
      else if (predict_taken)
         succ = icache_resp_i.addr + scan_i.imm;
      else
         succ = pc_f1 + 39'd4;
   end

   // redirect, miss refetch, then successor of the returned instruction
   always_comb
   begin
      if (cmd_fire)
      begin
         pc_n  = {fe_cmd_i.pc[vaddr_width_c-1:2], 2'b00};
         pcn_v = 1'b1;
      end
      else if (miss_r)
      begin
         pc_n  = pc_f2;
         pcn_v = 1'b1;
      end
      else if (resp_ok & fe_queue_ready_i)
      begin
         pc_n  = succ;
         pcn_v = 1'b1;
      end
      else
      begin
         pc_n  = npc_r;
         pcn_v = npc_v & ~miss_set;
      end
   end

   assign icache_req_v_o     = run_r & pcn_v & (~v_f1 | f1_done) & fe_queue_ready_i;
   assign icache_req_o.vaddr = pc_n;
   assign issue              = icache_req_v_o & icache_req_ready_i;

   assign btb_r_addr_o = pc_n;
   assign btb_w_v_o    = cmd_fire & fe_cmd_i.btb_write;
   assign btb_w_addr_o = fe_cmd_i.branch_pc;
   assign btb_w_tgt_o  = fe_cmd_i.pc;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         run_r      <= 1'b0;
         v_f1       <= 1'b0;
         sq_f1      <= 1'b0;
         miss_r     <= 1'b0;
         issue_q    <= 1'b0;
         btb_pred_r <= 1'b0;
         npc_v      <= 1'b1;
         npc_r      <= first_pc_p;
      end
      else
      begin
         run_r   <= 1'b1;
         miss_r  <= miss_set;
         issue_q <= issue;
         if (issue)
         begin
            v_f1  <= 1'b1;
            sq_f1 <= 1'b0;
            npc_v <= 1'b0;
         end
         else
         begin
            if (f1_done)
               v_f1 <= 1'b0;
            else if (cmd_fire & v_f1)
               sq_f1 <= 1'b1;
            npc_r <= pc_n;
            npc_v <= pcn_v;
         end
         if (issue_q)
            btb_pred_r <= btb_tgt_v_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (issue)
         pc_f1 <= pc_n;
      if (miss_set)
         pc_f2 <= pc_f1;
      if (issue_q)
         btb_tgt_r <= btb_tgt_i;
   end

   // exception entries leave only in the redirect cycle
   assign fe_queue_v_o = resp_ok | (cmd_fire & misaligned);

   always_comb
   begin
      fe_queue_o.exc_code = e_instr_addr_misaligned;
      if (cmd_fire)
      begin
         fe_queue_o.msg_type = e_fe_exception;
         fe_queue_o.pc       = fe_cmd_i.pc;
         fe_queue_o.instr    = '0;
      end
      else
      begin
         fe_queue_o.msg_type = e_fe_fetch;
         fe_queue_o.pc       = icache_resp_i.addr;
         fe_queue_o.instr    = icache_resp_i.instr;
      end
   end

endmodule

`default_nettype wire

/* fe_pkg.sv */
// front-end shared definitions
// widths, message encodings and the packed structs passed between blocks
`default_nettype none

package fe_pkg;

   localparam int vaddr_width_c = 39;
   localparam int instr_width_c = 32;

   typedef logic [vaddr_width_c-1:0] fe_vaddr_t;
   typedef logic [instr_width_c-1:0] fe_instr_t;

   typedef enum logic
   {
      e_fe_fetch     = 1'b0,
      e_fe_exception = 1'b1
   } fe_msg_type_e;

   // only the misaligned cause is produced by this front end
   typedef enum logic [1:0]
   {
      e_instr_addr_misaligned = 2'b00
   } fe_exc_code_e;

   typedef enum logic [1:0]
   {
      e_scan_other  = 2'b00,
      e_scan_branch = 2'b01,
      e_scan_jal    = 2'b10
   } fe_scan_class_e;

   typedef struct packed
   {
      fe_scan_class_e scan_class;
      fe_vaddr_t      imm;
   } fe_scan_s;

   // redirect from the back end, optionally training the btb
   typedef struct packed
   {
      fe_vaddr_t pc;
      fe_vaddr_t branch_pc;
      logic      btb_write;
   } fe_cmd_s;

   typedef struct packed
   {
      fe_vaddr_t vaddr;
   } fe_icache_req_s;

   typedef struct packed
   {
      fe_vaddr_t addr;
      fe_instr_t instr;
   } fe_icache_resp_s;

   typedef struct packed
   {
      fe_msg_type_e msg_type;
      fe_vaddr_t    pc;
      fe_instr_t    instr;
      fe_exc_code_e exc_code;
   } fe_queue_s;

endpackage

`default_nettype wire

/* fe_top.sv */
// instruction fetch front end
// PC generator with its branch target buffer and instruction scanner
`default_nettype none

module fe_top
  #(parameter int                btb_idx_width_p = 6,
    parameter fe_pkg::fe_vaddr_t first_pc_p      = 39'h80000000)
   (input  wire                     clk_i,
    input  wire                     reset_i,
    input  fe_pkg::fe_cmd_s         fe_cmd_i,
    input  wire                     fe_cmd_v_i,
    output logic                    fe_cmd_ready_o,
    output fe_pkg::fe_icache_req_s  icache_req_o,
    output logic                    icache_req_v_o,
    input  wire                     icache_req_ready_i,
    input  fe_pkg::fe_icache_resp_s icache_resp_i,
    input  wire                     icache_resp_v_i,
    input  wire                     icache_miss_i,
    output logic                    icache_resp_ready_o,
    output fe_pkg::fe_queue_s       fe_queue_o,
    output logic                    fe_queue_v_o,
    input  wire                     fe_queue_ready_i);

   import fe_pkg::*;

   fe_vaddr_t btb_r_addr, btb_tgt, btb_w_addr, btb_w_tgt;
   logic      btb_tgt_v, btb_w_v;
   fe_instr_t scan_instr;
   fe_scan_s  scan;

   fe_pc_gen #(.btb_idx_width_p(btb_idx_width_p), .first_pc_p(first_pc_p)) pc_gen
      (.clk_i, .reset_i,
       .fe_cmd_i, .fe_cmd_v_i, .fe_cmd_ready_o,
       .icache_req_o, .icache_req_v_o, .icache_req_ready_i,
       .icache_resp_i, .icache_resp_v_i, .icache_miss_i, .icache_resp_ready_o,
       .fe_queue_o, .fe_queue_v_o, .fe_queue_ready_i,
       .btb_r_addr_o(btb_r_addr), .btb_tgt_i(btb_tgt), .btb_tgt_v_i(btb_tgt_v),
       .btb_w_v_o(btb_w_v), .btb_w_addr_o(btb_w_addr), .btb_w_tgt_o(btb_w_tgt),
       .scan_instr_o(scan_instr), .scan_i(scan));

   fe_btb #(.btb_idx_width_p(btb_idx_width_p)) btb
      (.clk_i, .reset_i,
       .r_addr_i(btb_r_addr), .br_tgt_o(btb_tgt), .br_tgt_v_o(btb_tgt_v),
       .w_v_i(btb_w_v), .w_addr_i(btb_w_addr), .w_tgt_i(btb_w_tgt));

   fe_instr_scan instr_scan
      (.instr_i(scan_instr), .scan_o(scan));

endmodule

`default_nettype wire

/* tb_fe_top.sv */
// testbench for the fetch front end
// cache model, reference predictor and entry checker around fe_top
`default_nettype none

module tb_fe_top;

   import fe_pkg::*;

   localparam fe_vaddr_t first_pc_c = 39'h80000000;
   localparam fe_vaddr_t region_a_c = 39'h80010000;
   localparam fe_vaddr_t region_b_c = 39'h80020000;
   localparam fe_vaddr_t region_c_c = 39'h80030000;
   localparam int len_seq_c     = 16;
   localparam int len_static_c  = 40;
   localparam int len_btb_c     = 40;
   localparam int len_redir_c   = 10;
   localparam int len_stress_c  = 300;
   localparam int total_len_c   = len_seq_c + len_static_c + len_btb_c + len_redir_c
                                + len_stress_c;

   logic            clk_i = 1'b0;
   logic            reset_i = 1'b1;
   fe_cmd_s         fe_cmd_i = '0;
   logic            fe_cmd_v_i = 1'b0;
   logic            fe_cmd_ready_o;
   fe_icache_req_s  icache_req_o;
   logic            icache_req_v_o;
   logic            icache_req_ready_i = 1'b1;
   fe_icache_resp_s icache_resp_i = '0;
   logic            icache_resp_v_i = 1'b0;
   logic            icache_miss_i = 1'b0;
   logic            icache_resp_ready_o;
   fe_queue_s       fe_queue_o;
   logic            fe_queue_v_o;
   logic            fe_queue_ready_i = 1'b1;

   // sparse program, statically taken targets and trained btb entries
   fe_instr_t prog [fe_vaddr_t];
   fe_vaddr_t taken_tgt [fe_vaddr_t];
   fe_vaddr_t btb_ref [fe_vaddr_t];

   integer    seed = 32'hfa03359f;
   int        n_entries = 0;
   logic      random_on = 1'b0;
   fe_vaddr_t exp_pc;
   logic      busy, pending, miss_now;
   int        wait_cnt;
   fe_vaddr_t req_addr;

   fe_top DUT (.*);

   always #2 clk_i = ~clk_i;

   task automatic expect_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   // background words use the addi opcode and never branch
   function automatic fe_instr_t fill_word(input fe_vaddr_t a);
      return {a[38:14] ^ a[24:0], 7'b0010011};
   endfunction

   function automatic fe_instr_t mem_read(input fe_vaddr_t a);
      return prog.exists(a) ? prog[a] : fill_word(a);
   endfunction

   function automatic fe_instr_t encode_b(input int off);
      logic [12:0] imm;
      imm = off[12:0];
      return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b001, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic fe_instr_t encode_j(input int off);
      logic [20:0] imm;
      imm = off[20:0];
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
   endfunction

   // backward branches and every jal count as taken
   task automatic place_branch(input fe_vaddr_t pc, input int off, input logic is_jal);
      prog[pc] = is_jal ? encode_j(off) : encode_b(off);
      if (is_jal || off < 0)
         taken_tgt[pc] = pc + fe_vaddr_t'(off);
   endtask

   function automatic fe_vaddr_t next_pc(input fe_vaddr_t a);
      if (btb_ref.exists(a))
         return btb_ref[a];
      else if (taken_tgt.exists(a))
         return taken_tgt[a];
      else
         return a + 39'd4;
   endfunction

   task automatic load_program();
      // loop a has a forward jal, a forward bne and a backward bne
      place_branch(region_a_c + 39'h10, 64, 1'b1);
      place_branch(region_a_c + 39'h30, 256, 1'b0);
      place_branch(region_a_c + 39'h50, -48, 1'b0);
      // the forward bne at +8 of loop b gets a btb entry
      place_branch(region_b_c + 39'h08, 128, 1'b0);
      place_branch(region_b_c + 39'h20, -32, 1'b1);
      place_branch(region_b_c + 39'h88, -136, 1'b1);
   endtask

   task automatic wait_entries(input int n);
      int target;
      target = n_entries + n;
      while (n_entries < target)
         @(posedge clk_i);
   endtask

   task automatic redirect(input fe_vaddr_t tgt, input logic wr, input fe_vaddr_t br);
      fe_cmd_i   <= '{pc: tgt, branch_pc: br, btb_write: wr};
      fe_cmd_v_i <= 1'b1;
      @(posedge clk_i);
      while (!fe_cmd_ready_o)
         @(posedge clk_i);
      fe_cmd_v_i <= 1'b0;
   endtask

   task automatic sequential_fetch();
      wait_entries(len_seq_c);
   endtask

   task automatic static_prediction();
      redirect(region_a_c, 1'b0, '0);
      wait_entries(len_static_c);
   endtask

   task automatic btb_prediction();
      redirect(region_b_c, 1'b0, '0);
      wait_entries(10);
      redirect(region_b_c + 39'h88, 1'b1, region_b_c + 39'h08);
      wait_entries(len_btb_c - 10);
   endtask

   task automatic redirect_targets();
      redirect(region_c_c, 1'b0, '0);
      wait_entries(4);
      redirect(region_c_c + 39'h102, 1'b0, '0);
      wait_entries(len_redir_c - 4);
   endtask

   task automatic random_backpressure();
      random_on <= 1'b1;
      redirect(region_a_c, 1'b0, '0);
      wait_entries(150);
      redirect(region_b_c, 1'b0, '0);
      wait_entries(100);
      redirect(region_c_c + 39'h206, 1'b0, '0);
      wait_entries(len_stress_c - 250);
   endtask

   // cache model with one request in flight and random ready signals
   always @(posedge clk_i)
   begin
      if (reset_i)
      begin
         busy    = 1'b0;
         pending = 1'b0;
         icache_resp_v_i <= 1'b0;
         icache_miss_i   <= 1'b0;
      end
      else
      begin
         if ((icache_resp_v_i && icache_resp_ready_o) || icache_miss_i)
         begin
            busy = 1'b0;
            icache_resp_v_i <= 1'b0;
            icache_miss_i   <= 1'b0;
         end
         if (icache_req_v_o && icache_req_ready_i)
         begin
            assert (!busy)
            else
            begin
               $display("cache model got a second request before answering the first");
               $display(">>> FAIL");
               $fatal(1);
            end
            busy     = 1'b1;
            pending  = 1'b1;
            req_addr = icache_req_o.vaddr;
            wait_cnt = random_on ? $unsigned($random(seed)) % 3 : 0;
            miss_now = random_on && (($random(seed) & 7) == 0);
         end
         if (pending)
         begin
            if (wait_cnt == 0)
            begin
               pending = 1'b0;
               if (miss_now)
                  icache_miss_i <= 1'b1;
               else
               begin
                  icache_resp_v_i <= 1'b1;
                  icache_resp_i   <= '{addr: req_addr, instr: mem_read(req_addr)};
               end
            end
            else
               wait_cnt = wait_cnt - 1;
         end
         fe_queue_ready_i   <= !random_on || (($random(seed) & 3) != 0);
         icache_req_ready_i <= !random_on || (($random(seed) & 7) != 0);
      end
   end

   // every transferred entry against the reference stream
   always @(posedge clk_i)
   begin
      if (reset_i)
         exp_pc = first_pc_c;
      else if (fe_cmd_v_i && fe_cmd_ready_o)
      begin
         if (fe_cmd_i.pc[1:0] != 2'b00)
         begin
            expect_eq("fe_queue_v_o", 64'(fe_queue_v_o), 64'd1);
            expect_eq("fe_queue_o.msg_type", 64'(fe_queue_o.msg_type), 64'(e_fe_exception));
            expect_eq("fe_queue_o.pc", 64'(fe_queue_o.pc), 64'(fe_cmd_i.pc));
            expect_eq("fe_queue_o.instr", 64'(fe_queue_o.instr), 64'd0);
            expect_eq("fe_queue_o.exc_code", 64'(fe_queue_o.exc_code),
                      64'(e_instr_addr_misaligned));
            n_entries <= n_entries + 1;
         end
         else
            expect_eq("fe_queue_v_o", 64'(fe_queue_v_o), 64'd0);
         if (fe_cmd_i.btb_write)
            btb_ref[fe_cmd_i.branch_pc] = fe_cmd_i.pc;
         exp_pc = fe_cmd_i.pc & ~fe_vaddr_t'(3);
      end
      else if (fe_queue_v_o && fe_queue_ready_i)
      begin
         expect_eq("fe_queue_o.msg_type", 64'(fe_queue_o.msg_type), 64'(e_fe_fetch));
         expect_eq("fe_queue_o.pc", 64'(fe_queue_o.pc), 64'(exp_pc));
         expect_eq("fe_queue_o.instr", 64'(fe_queue_o.instr), 64'(mem_read(exp_pc)));
         exp_pc = next_pc(exp_pc);
         n_entries <= n_entries + 1;
      end
   end

   initial
   begin
      repeat (total_len_c * 40) @(posedge clk_i);
      $display("timeout, the tests did not finish in %0d cycles", total_len_c * 40);
      $display(">>> FAIL");
      $fatal(1);
   end

   initial
   begin
      load_program();
      repeat (3) @(posedge clk_i);
      expect_eq("icache_req_v_o", 64'(icache_req_v_o), 64'd0);
      expect_eq("fe_queue_v_o", 64'(fe_queue_v_o), 64'd0);
      expect_eq("fe_cmd_ready_o", 64'(fe_cmd_ready_o), 64'd0);
      @(posedge clk_i);
      reset_i <= 1'b0;
      sequential_fetch();
      static_prediction();
      btb_prediction();
      redirect_targets();
      random_backpressure();
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
fe_pkg.sv
fe_btb.sv
fe_instr_scan.sv
fe_pc_gen.sv
fe_top.sv
tb_fe_top.sv
